/* src/core_cfg_pkg.sv */
package core_cfg_pkg;

	// ----------------------------------------------------------
	// Window geometry
	// ----------------------------------------------------------

	localparam int WIN_SIZE = 9;	// 3x3 window

	// ----------------------------------------------------------
	// Q8.8 arithmetic
	// ----------------------------------------------------------

	localparam int FRAC_BITS = 8;

	// Saturation bounds of a Q8.8 word
	localparam int Q16_MAX = 32767;
	localparam int Q16_MIN = -32768;

	// ----------------------------------------------------------
	// Stage latencies in okClk cycles
	// ----------------------------------------------------------

	localparam int CONV_LATENCY = 3;	// Multiply, adder tree, bias and saturate
	localparam int POOL_LATENCY = 2;	// Group max, final max

endpackage

/* src/cnn_types_pkg.sv */
package cnn_types_pkg;

	// ----------------------------------------------------------
	// Fixed-point scalar
	// ----------------------------------------------------------

	// Signed Q8.8 with 8 integer and 8 fraction bits
	typedef logic signed [15:0] q16_t;

	// ----------------------------------------------------------
	// Stream payloads
	// ----------------------------------------------------------

	// One host pipe word with the weight in the upper half
	typedef struct packed {
		q16_t weight;	// Bits 31:16
		q16_t pixel;	// Bits 15:0
	} pix_wgt_t;

	// Slot 0 holds the oldest element
	typedef pix_wgt_t [core_cfg_pkg::WIN_SIZE-1:0] conv_win_t;

	// Nine conv results feeding one max-pool window
	typedef q16_t [core_cfg_pkg::WIN_SIZE-1:0] pool_win_t;

	// ----------------------------------------------------------
	// Output pipe word
	// ----------------------------------------------------------

	// Result index within the frame sits above the pooled value
	typedef struct packed {
		logic [15:0] seq;	// Bits 31:16
		q16_t value;		// Bits 15:0
	} out_word_t;

endpackage

/* src/window_collector.sv */
`timescale 1ns/10ps

module window_collector #(
	parameter type elem_t = cnn_types_pkg::q16_t
) (
	input  logic okClk,
	input  logic arst_n,

	// Element stream
	input  logic elem_write,
	input  elem_t elem_data,

	// Complete window, oldest element in slot 0
	output logic win_strobe,
	output elem_t [core_cfg_pkg::WIN_SIZE-1:0] win_data
);
	import core_cfg_pkg::*;

	logic [$clog2(WIN_SIZE)-1:0] elem_cnt;
	logic last_elem;

	// Ninth element of the current window
	assign last_elem = elem_write && (int'(elem_cnt) == WIN_SIZE - 1);

	// ----------------------------------------------------------
	// Element counter and window strobe
	// ----------------------------------------------------------

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			elem_cnt   <= '0;
			win_strobe <= 1'b0;
		end else begin
			win_strobe <= last_elem;
			if (last_elem) begin
				elem_cnt <= '0;
			end else if (elem_write) begin
				elem_cnt <= elem_cnt + 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// Window shift register
	// ----------------------------------------------------------

	// New element enters the top slot, older ones move down
	always_ff @(posedge okClk) begin
		if (elem_write) begin
			win_data <= {elem_data, win_data[WIN_SIZE-1:1]};
		end
	end

endmodule

/* src/conv_3x3.sv */
`timescale 1ns/10ps

module conv_3x3 (
	input  logic okClk,
	input  logic arst_n,

	// Window from the collector
	input  logic win_strobe,
	input  cnn_types_pkg::conv_win_t win_data,

	// Quasi-static controls
	input  cnn_types_pkg::q16_t bias,
	input  logic relu_en,

	// Result stream
	output logic conv_write,
	output cnn_types_pkg::q16_t conv_data
);
	import cnn_types_pkg::*;
	import core_cfg_pkg::*;

	logic [CONV_LATENCY-1:0] vld;		// One valid bit per stage

	logic signed [31:0] prod [WIN_SIZE];	// Full Q16.16 products
	q16_t bias_s1;
	logic relu_s1;

	logic signed [33:0] psum [3];		// One partial sum per window row
	q16_t bias_s2;
	logic relu_s2;

	logic signed [35:0] acc;
	logic signed [35:0] acc_shr;
	q16_t result;

	// Valid bits walk alongside the data
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			vld <= '0;
		end else begin
			vld <= {vld[CONV_LATENCY-2:0], win_strobe};
		end
	end

	// ----------------------------------------------------------
	// Stage 1 products and control capture
	// ----------------------------------------------------------

	always_ff @(posedge okClk) begin
		if (win_strobe) begin
			for (int i = 0; i < WIN_SIZE; i++) begin
				prod[i] <= win_data[i].pixel * win_data[i].weight;
			end
			bias_s1 <= bias;
			relu_s1 <= relu_en;
		end
	end

	// ----------------------------------------------------------
	// Stage 2 adder tree down to three partial sums
	// ----------------------------------------------------------

	always_ff @(posedge okClk) begin
		if (vld[0]) begin
			for (int g = 0; g < 3; g++) begin
				psum[g] <= 34'(prod[3*g]) + 34'(prod[3*g+1]) + 34'(prod[3*g+2]);
			end
			bias_s2 <= bias_s1;
			relu_s2 <= relu_s1;
		end
	end

	// ----------------------------------------------------------
	// Stage 3 bias, rescale, saturate, ReLU
	// ----------------------------------------------------------

	always_comb begin
		// Bias moved up to the Q16.16 scale of the products
		acc = 36'(psum[0]) + 36'(psum[1]) + 36'(psum[2]) + (36'(bias_s2) <<< FRAC_BITS);
		acc_shr = acc >>> FRAC_BITS;	// Floors toward minus infinity

		if (acc_shr > Q16_MAX) begin
			result = q16_t'(Q16_MAX);
		end else if (acc_shr < Q16_MIN) begin
			result = q16_t'(Q16_MIN);
		end else begin
			result = acc_shr[15:0];
		end

		if (relu_s2 && result[15]) begin
			result = '0;
		end
	end

	always_ff @(posedge okClk) begin
		if (vld[CONV_LATENCY-2]) begin
			conv_data <= result;
		end
	end

	assign conv_write = vld[CONV_LATENCY-1];

endmodule

/* src/pool_3x3.sv */
`timescale 1ns/10ps

module pool_3x3 (
	input  logic okClk,
	input  logic arst_n,

	// Window of nine conv results
	input  logic win_strobe,
	input  cnn_types_pkg::pool_win_t win_data,

	// Pooled stream
	output logic pool_write,
	output cnn_types_pkg::q16_t pool_data
);
	import cnn_types_pkg::*;
	import core_cfg_pkg::*;

	logic [POOL_LATENCY-1:0] vld;
	q16_t grp_max [3];	// Max of each window row

	// Signed maximum of two Q8.8 values
	function automatic q16_t smax(input q16_t a, input q16_t b);
		return (a > b) ? a : b;
	endfunction

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			vld <= '0;
		end else begin
			vld <= {vld[POOL_LATENCY-2:0], win_strobe};
		end
	end

	// ----------------------------------------------------------
	// Stage 1 row maxima
	// ----------------------------------------------------------

	always_ff @(posedge okClk) begin
		if (win_strobe) begin
			for (int g = 0; g < 3; g++) begin
				grp_max[g] <= smax(smax(win_data[3*g], win_data[3*g+1]), win_data[3*g+2]);
			end
		end
	end

	// ----------------------------------------------------------
	// Stage 2 final maximum
	// ----------------------------------------------------------

	always_ff @(posedge okClk) begin
		if (vld[POOL_LATENCY-2]) begin
			pool_data <= smax(smax(grp_max[0], grp_max[1]), grp_max[2]);
		end
	end

	assign pool_write = vld[POOL_LATENCY-1];

endmodule

/* src/result_framer.sv */
`timescale 1ns/10ps

module result_framer (
	input  logic okClk,
	input  logic arst_n,

	// Pooled stream
	input  logic pool_write,
	input  cnn_types_pkg::q16_t pool_data,

	// Results per frame, at least 1
	input  logic [15:0] frame_len,

	// Output pipe
	output logic out_write,
	output cnn_types_pkg::out_word_t out_data,
	output logic frame_done
);
	import cnn_types_pkg::*;

	logic [15:0] seq;
	logic last_result;

	assign last_result = pool_write && (seq == 16'(frame_len - 16'd1));

	// ----------------------------------------------------------
	// Sequence counter and strobes
	// ----------------------------------------------------------

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			seq        <= '0;
			out_write  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			out_write  <= pool_write;
			frame_done <= last_result;	// Rides with the last out_write
			if (last_result) begin
				seq <= '0;
			end else if (pool_write) begin
				seq <= seq + 16'd1;
			end
		end
	end

	// Output word packing
	always_ff @(posedge okClk) begin
		if (pool_write) begin
			out_data <= out_word_t'{seq: seq, value: pool_data};
		end
	end

endmodule

/* src/squeeze_core_top.sv */
`timescale 1ns/10ps

module squeeze_core_top (
	input  logic okClk,
	input  logic arst_n,

	// Host pipe words
	input  logic in_write,
	input  cnn_types_pkg::pix_wgt_t in_data,

	// Quasi-static controls, changed only between frames
	input  cnn_types_pkg::q16_t bias,
	input  logic relu_en,
	input  logic [15:0] frame_len,

	// Conv result tap
	output logic conv_write,
	output cnn_types_pkg::q16_t conv_data,

	// Output pipe
	output logic out_write,
	output cnn_types_pkg::out_word_t out_data,
	output logic frame_done
);
	import cnn_types_pkg::*;

	logic conv_win_strobe;
	conv_win_t conv_win;
	logic pool_win_strobe;
	pool_win_t pool_win;
	logic pool_write;
	q16_t pool_data;

	// ----------------------------------------------------------
	// Convolution path
	// ----------------------------------------------------------

	window_collector #(.elem_t(pix_wgt_t)) i_conv_collector (
		.okClk      (okClk),
		.arst_n     (arst_n),
		.elem_write (in_write),
		.elem_data  (in_data),
		.win_strobe (conv_win_strobe),
		.win_data   (conv_win)
	);

	conv_3x3 i_conv_3x3 (
		.okClk      (okClk),
		.arst_n     (arst_n),
		.win_strobe (conv_win_strobe),
		.win_data   (conv_win),
		.bias       (bias),
		.relu_en    (relu_en),
		.conv_write (conv_write),
		.conv_data  (conv_data)
	);

	// ----------------------------------------------------------
	// Pooling path and framing
	// ----------------------------------------------------------

	window_collector #(.elem_t(q16_t)) i_pool_collector (
		.okClk      (okClk),
		.arst_n     (arst_n),
		.elem_write (conv_write),
		.elem_data  (conv_data),
		.win_strobe (pool_win_strobe),
		.win_data   (pool_win)
	);

	pool_3x3 i_pool_3x3 (
		.okClk      (okClk),
		.arst_n     (arst_n),
		.win_strobe (pool_win_strobe),
		.win_data   (pool_win),
		.pool_write (pool_write),
		.pool_data  (pool_data)
	);

	result_framer i_result_framer (
		.okClk      (okClk),
		.arst_n     (arst_n),
		.pool_write (pool_write),
		.pool_data  (pool_data),
		.frame_len  (frame_len),
		.out_write  (out_write),
		.out_data   (out_data),
		.frame_done (frame_done)
	);

endmodule

/* testbench/squeeze_core_asserts.sv */
`timescale 1ns/10ps

module squeeze_core_asserts (
	input logic okClk,
	input logic arst_n,
	input logic in_write,
	input logic conv_write,
	input logic pool_write,
	input logic out_write,
	input logic frame_done
);
	import core_cfg_pkg::*;

	int fail_cnt = 0;	// Summed up by the testbench at the end
	logic [3:0] word_cnt;
	logic ninth_word;

	assign ninth_word = in_write && (int'(word_cnt) == WIN_SIZE - 1);

	// Host words within the current conv window
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			word_cnt <= '0;
		end else if (ninth_word) begin
			word_cnt <= '0;
		end else if (in_write) begin
			word_cnt <= word_cnt + 4'd1;
		end
	end

	// ----------------------------------------------------------
	// Protocol properties
	// ----------------------------------------------------------

	done_with_write: assert property (
		@(posedge okClk) disable iff (!arst_n) frame_done |-> out_write
	) else begin
		fail_cnt++;
		$error("frame_done pulsed without out_write");
	end

	strobes_known: assert property (
		@(posedge okClk) disable iff (!arst_n)
		!$isunknown({in_write, conv_write, pool_write, out_write, frame_done})
	) else begin
		fail_cnt++;
		$error("strobe is X after reset");
	end

	// Exactly four cycles from the ninth word to its conv result
	conv_latency: assert property (
		@(posedge okClk) disable iff (!arst_n) conv_write == $past(ninth_word, 4)
	) else begin
		fail_cnt++;
		$error("conv_write not 4 cycles after the ninth host word");
	end

endmodule

bind squeeze_core_top squeeze_core_asserts i_asserts (.*);

/* testbench/tb_squeeze_core.sv */
`timescale 1ns/10ps

module tb_squeeze_core;
	import cnn_types_pkg::*;
	import core_cfg_pkg::*;

	localparam logic [31:0] LCG_SEED = 32'hb9f8;
	localparam int DRAIN_TIMEOUT = 300;	// Cycles for the pipeline to empty

	logic okClk = 1'b0;
	logic arst_n;
	logic in_write;
	pix_wgt_t in_data;
	q16_t bias;
	logic relu_en;
	logic [15:0] frame_len;
	logic conv_write;
	q16_t conv_data;
	logic out_write;
	out_word_t out_data;
	logic frame_done;

	logic [31:0] lcg_state = LCG_SEED;
	pix_wgt_t win_words [WIN_SIZE];	// Partial conv window
	q16_t pool_vals [WIN_SIZE];	// Partial pool window
	int word_cnt;
	int conv_cnt;
	logic [15:0] seq_model;
	q16_t exp_conv [$];
	out_word_t exp_out [$];
	logic exp_last [$];
	int mismatch_cnt;
	int other_cnt;
	int sat_hi_cnt;
	int sat_lo_cnt;

	squeeze_core_top i_squeeze_core_top (.*);

	always #4 okClk = ~okClk;	// 8 ns period

	// ----------------------------------------------------------
	// Random source and reference model
	// ----------------------------------------------------------

	// LCG step, signed value of the given width from the top bits
	function automatic q16_t rand_val(input int bits);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return q16_t'($signed(lcg_state[31:16]) >>> (16 - bits));
	endfunction

	function automatic q16_t conv_ref(input pix_wgt_t w [WIN_SIZE], input q16_t b,
			input logic relu);
		longint acc;
		acc = longint'(b) <<< FRAC_BITS;	// Bias on the product scale
		for (int i = 0; i < WIN_SIZE; i++) begin
			acc += longint'(w[i].pixel) * longint'(w[i].weight);
		end
		acc = acc >>> FRAC_BITS;
		if (acc > Q16_MAX) begin
			acc = Q16_MAX;
		end else if (acc < Q16_MIN) begin
			acc = Q16_MIN;
		end
		if (relu && acc < 0) begin
			acc = 0;
		end
		return q16_t'(acc);
	endfunction

	function automatic q16_t pool_ref(input q16_t v [WIN_SIZE]);
		q16_t m;
		m = v[0];
		for (int i = 1; i < WIN_SIZE; i++) begin
			if (v[i] > m) begin
				m = v[i];
			end
		end
		return m;
	endfunction

	// Follows one host word through both collectors and the framer
	function automatic void model_word(input pix_wgt_t w);
		q16_t c;
		win_words[word_cnt] = w;
		word_cnt++;
		if (word_cnt < WIN_SIZE) begin
			return;
		end
		word_cnt = 0;
		c = conv_ref(win_words, bias, relu_en);
		exp_conv.push_back(c);
		sat_hi_cnt += int'(c == q16_t'(Q16_MAX));
		sat_lo_cnt += int'(c == q16_t'(Q16_MIN));
		pool_vals[conv_cnt] = c;
		conv_cnt++;
		if (conv_cnt < WIN_SIZE) begin
			return;
		end
		conv_cnt = 0;
		exp_out.push_back(out_word_t'{seq: seq_model, value: pool_ref(pool_vals)});
		exp_last.push_back(seq_model == frame_len - 16'd1);
		seq_model = (seq_model == frame_len - 16'd1) ? 16'd0 : seq_model + 16'd1;
	endfunction

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------

	// gap_mask bounds the idle cycles after the word
	task automatic send_word(input int bits, input int gap_mask);
		pix_wgt_t w;
		int gap;
		w.pixel = rand_val(bits);
		w.weight = rand_val(bits);
		gap = int'(rand_val(16)) & gap_mask;
		@(posedge okClk);
		in_write <= 1'b1;
		in_data <= w;
		model_word(w);
		repeat (gap) begin
			@(posedge okClk);
			in_write <= 1'b0;
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_conv.size() + exp_out.size() != 0 && cycles < DRAIN_TIMEOUT) begin
			@(posedge okClk);
			cycles++;
		end
		assert (exp_conv.size() + exp_out.size() == 0) else begin
			other_cnt++;
			$display("Timeout at %0t: %0d conv and %0d output results never arrived",
				$time, exp_conv.size(), exp_out.size());
			exp_conv.delete();
			exp_out.delete();
			exp_last.delete();
		end
	endtask

	// One frame with controls that hold for its whole length
	task automatic run_frame(input q16_t b, input logic relu, input logic [15:0] len,
			input int bits, input int gap_mask);
		@(posedge okClk);
		bias <= b;
		relu_en <= relu;
		frame_len <= len;
		for (int n = 0; n < int'(len) * WIN_SIZE * WIN_SIZE; n++) begin
			send_word(bits, gap_mask);
		end
		@(posedge okClk);
		in_write <= 1'b0;
		wait_drain();
	endtask

	// One output, four conv windows and five loose words, then reset
	task automatic reset_mid_window();
		@(posedge okClk);
		frame_len <= 16'd3;
		for (int n = 0; n < WIN_SIZE * WIN_SIZE + 4 * WIN_SIZE + 5; n++) begin
			send_word(8, 0);
		end
		@(posedge okClk);
		in_write <= 1'b0;
		wait_drain();
		@(posedge okClk);
		arst_n <= 1'b0;
		word_cnt = 0;
		conv_cnt = 0;
		seq_model = '0;
		repeat (4) @(posedge okClk);
		arst_n <= 1'b1;
	endtask

	// ----------------------------------------------------------
	// Output comparison
	// ----------------------------------------------------------

	always @(negedge okClk) begin : compare_outputs
		q16_t exp_c;
		out_word_t exp_o;
		logic exp_l;
		if (arst_n && conv_write) begin
			assert (exp_conv.size() != 0) else begin
				other_cnt++;
				$display("Error at %0t: conv_write with no window sent", $time);
			end
			if (exp_conv.size() != 0) begin
				exp_c = exp_conv.pop_front();
				assert (conv_data == exp_c) else begin
					mismatch_cnt++;
					$display("MISMATCH at %0t: conv_data %0d, expected %0d",
						$time, conv_data, exp_c);
				end
			end
		end
		if (arst_n && out_write) begin
			assert (exp_out.size() != 0) else begin
				other_cnt++;
				$display("Error at %0t: out_write with no pooled window due", $time);
			end
			if (exp_out.size() != 0) begin
				exp_o = exp_out.pop_front();
				exp_l = exp_last.pop_front();
				assert (out_data == exp_o && frame_done == exp_l) else begin
					mismatch_cnt++;
					$display("MISMATCH at %0t: seq %0d value %0d done %0b, expected %0d %0d %0b",
						$time, out_data.seq, out_data.value, frame_done,
						exp_o.seq, exp_o.value, exp_l);
				end
			end
		end
	end

	initial begin
		arst_n = 1'b0;
		in_write = 1'b0;
		in_data = '0;
		bias = '0;
		relu_en = 1'b0;
		frame_len = 16'd1;
		word_cnt = 0;
		conv_cnt = 0;
		seq_model = '0;
		repeat (16) @(posedge okClk);
		arst_n <= 1'b1;

		run_frame(16'sd40, 1'b0, 16'd3, 7, 0);	// Small values with bias
		run_frame(16'sh4000, 1'b0, 16'd2, 16, 0);
		run_frame(-16'sh4000, 1'b0, 16'd2, 16, 0);
		assert (sat_hi_cnt > 0 && sat_lo_cnt > 0) else begin
			other_cnt++;
			$display("Error: large-value frames never reached both saturation bounds");
		end
		run_frame(-16'sd300, 1'b1, 16'd3, 8, 0);	// ReLU on, then off
		run_frame(-16'sd300, 1'b0, 16'd3, 8, 0);
		run_frame(-16'sd2000, 1'b0, 16'd2, 7, 0);	// Every pool window negative
		run_frame(16'sd10, 1'b0, 16'd1, 8, 3);
		run_frame(16'sd10, 1'b1, 16'd1, 8, 1);
		run_frame(16'sd10, 1'b1, 16'd3, 8, 1);
		reset_mid_window();
		run_frame(16'sd0, 1'b0, 16'd3, 8, 1);	// Seq restarts at 0

		$display("Errors: %0d mismatches, %0d other, %0d assertion failures",
			mismatch_cnt, other_cnt, i_squeeze_core_top.i_asserts.fail_cnt);
		if (mismatch_cnt + other_cnt + i_squeeze_core_top.i_asserts.fail_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
src/core_cfg_pkg.sv
src/cnn_types_pkg.sv
src/window_collector.sv
src/conv_3x3.sv
src/pool_3x3.sv
src/result_framer.sv
src/squeeze_core_top.sv
testbench/squeeze_core_asserts.sv
testbench/tb_squeeze_core.sv

/* Makefile */
TOP = tb_squeeze_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
